// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module s86_tb \
	-f verilog.f -o s86_sim &&
./obj_dir/s86_sim | tee sim.log
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== s86_cfg.svh ====
`ifndef S86_CFG_SVH
`define S86_CFG_SVH

////////////////////
// Horizontal raster
////////////////////

// Visible pixels, then whole line in clocks
`define S86_H_ACTIVE 48
`define S86_H_TOTAL 64
// Line sync pulse window
`define S86_H_SYNC_START 52
`define S86_H_SYNC_LEN 4

////////////////////
// Vertical raster
////////////////////

// Visible lines, then whole frame in lines
`define S86_V_ACTIVE 32
`define S86_V_TOTAL 40
// Frame sync pulse window, in lines
`define S86_V_SYNC_START 34
`define S86_V_SYNC_LEN 2

// Counter position to RGB out, in clocks
`define S86_PIPE_DEPTH 4
// Bits per colour component
`define S86_COMPONENT_DEPTH 4

// Layer priorities, larger value drawn on top
`define S86_BG_PRIORITY 2
`define S86_FG_PRIORITY 3

`endif

// ==== s86_layer_mixer.sv ====
`default_nettype none

`include "s86_cfg.svh"

module s86_layer_mixer (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire s86_pkg::layer_pixel_t bg,
	input  wire s86_pkg::layer_pixel_t fg,
	input  wire [1:0]             layer_enable,
	output s86_pkg::layer_pixel_t pixel
);

	import s86_pkg::*;

	// Fixed layer order from the priority values
	localparam bit FG_ON_TOP = (`S86_FG_PRIORITY > `S86_BG_PRIORITY);

	// Visible means enabled and not transparent
	logic bg_opaque;
	logic fg_opaque;

	// Layers sorted by priority
	layer_pixel_t upper_px;
	layer_pixel_t lower_px;
	logic         upper_opaque;
	logic         lower_opaque;

	layer_pixel_t winner;

	// Bit 0 background, bit 1 foreground
	assign bg_opaque = layer_enable[0] && (bg.index != 4'd0);
	assign fg_opaque = layer_enable[1] && (fg.index != 4'd0);

	assign upper_px = FG_ON_TOP ? fg : bg;
	assign lower_px = FG_ON_TOP ? bg : fg;
	assign upper_opaque = FG_ON_TOP ? fg_opaque : bg_opaque;
	assign lower_opaque = FG_ON_TOP ? bg_opaque : fg_opaque;

	always_comb begin
		if (upper_opaque) begin
			winner = upper_px;
		end else if (lower_opaque) begin
			winner = lower_px;
		end else begin
			// Backdrop, palette 0 entry 0
			winner = '0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pixel <= '0;
		end else begin
			pixel <= winner;
		end
	end

endmodule

`default_nettype wire

// ==== s86_palette.sv ====
`default_nettype none

`include "s86_cfg.svh"

module s86_palette (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire s86_pkg::layer_pixel_t pixel,
	input  wire                   blank_n,
	output logic [7:0]            rg_addr,
	input  wire [2*`S86_COMPONENT_DEPTH-1:0] rg_data,
	output logic [7:0]            b_addr,
	input  wire [`S86_COMPONENT_DEPTH-1:0]   b_data,
	output s86_pkg::rgb_t         rgb
);

	import s86_pkg::*;

	rgb_t rgb_next;

	// Both colour PROMs share the same 256 entry index
	assign rg_addr = {pixel.palette, pixel.index};
	assign b_addr = {pixel.palette, pixel.index};

	// Red in the low nibble, green in the high nibble
	assign rgb_next.red = rg_data[`S86_COMPONENT_DEPTH-1:0];
	assign rgb_next.green = rg_data[2*`S86_COMPONENT_DEPTH-1:`S86_COMPONENT_DEPTH];
	assign rgb_next.blue = b_data;

	////////////////////
	// Output register
	////////////////////

	// Black outside the visible area
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rgb <= '0;
		end else if (!blank_n) begin
			rgb <= '0;
		end else begin
			rgb <= rgb_next;
		end
	end

endmodule

`default_nettype wire

// ==== s86_pkg.sv ====
`default_nettype none

`include "s86_cfg.svh"

package s86_pkg;

	// Current raster counter position
	typedef struct packed {
		logic [6:0] hcount;
		logic [5:0] vcount;
	} raster_pos_t;

	// Sync and blank strobes, all active low
	typedef struct packed {
		logic hsync_n;
		logic vsync_n;
		logic hblank_n;
		logic vblank_n;
	} video_sync_t;

	// Tile-map word as stored in the tile SRAM
	typedef struct packed {
		logic [7:0] code;
		logic [3:0] palette;
		logic [3:0] unused;
	} tile_entry_t;

	// Layer pixel, index 0 is transparent
	typedef struct packed {
		logic [3:0] palette;
		logic [3:0] index;
	} layer_pixel_t;

	// Final colour
	typedef struct packed {
		logic [`S86_COMPONENT_DEPTH-1:0] red;
		logic [`S86_COMPONENT_DEPTH-1:0] green;
		logic [`S86_COMPONENT_DEPTH-1:0] blue;
	} rgb_t;

endpackage

`default_nettype wire

// ==== s86_tb.sv ====
`default_nettype none

`include "s86_cfg.svh"

module s86_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import s86_pkg::*;

	// Wait limits in clocks
	localparam int FRAME_LIMIT = 2 * `S86_H_TOTAL * `S86_V_TOTAL;
	localparam int RESET_LIMIT = 20;
	localparam video_sync_t SYNC_IDLE = '{hsync_n: 1'b1, vsync_n: 1'b1,
		hblank_n: 1'b0, vblank_n: 1'b0};

	logic        clk;
	logic        arst_n;
	logic [5:0]  bg_scroll_x;
	logic [5:0]  fg_scroll_x;
	logic [1:0]  layer_enable;
	logic [5:0]  bg_map_addr;
	logic [15:0] bg_map_data;
	logic [13:0] bg_gfx_addr;
	logic [3:0]  bg_gfx_data;
	logic [5:0]  fg_map_addr;
	logic [15:0] fg_map_data;
	logic [13:0] fg_gfx_addr;
	logic [3:0]  fg_gfx_data;
	logic [7:0]  rg_addr;
	logic [2*`S86_COMPONENT_DEPTH-1:0] rg_data;
	logic [7:0]  b_addr;
	logic [`S86_COMPONENT_DEPTH-1:0] b_data;
	video_sync_t vid_sync;
	rgb_t        vid_rgb;

	////////////////////
	// Memory models
	////////////////////

	logic [15:0] bg_map [64];
	logic [15:0] fg_map [64];
	logic [3:0]  bg_gfx [16384];
	logic [3:0]  fg_gfx [16384];
	logic [7:0]  rg_prom [256];
	logic [3:0]  b_prom [256];

	// Tile SRAM and ROMs answer in the same clock
	assign bg_map_data = bg_map[bg_map_addr];
	assign fg_map_data = fg_map[fg_map_addr];
	assign bg_gfx_data = bg_gfx[bg_gfx_addr];
	assign fg_gfx_data = fg_gfx[fg_gfx_addr];
	assign rg_data = rg_prom[rg_addr];
	assign b_data = b_prom[b_addr];

	string cur_test;
	int    main_errs;
	int    mon_errs = 0;
	int    start_errs;
	int    tests_run;
	int    tests_failed;
	bit    timed_out = 1'b0;
	// Reference raster locks on the first frame sync
	bit    locked = 1'b0;
	int    ref_h = 0;
	int    ref_v = 0;
	logic  prev_vsync_n = 1'b1;
	int    frame_count = 0;
	// Overlap cases seen with both layers on
	int    cnt_fg_top = 0;
	int    cnt_bg_show = 0;
	int    cnt_backdrop = 0;

	s86_tb_clk clk_i (.clk(clk), .arst_n(arst_n));

	s86_video dut_i (.*);

	task automatic fill_memories();
		int          i;
		tile_entry_t entry;
		void'($urandom(21043));
		for (i = 0; i < 64; i++) begin
			bg_map[6'(i)] = 16'($urandom);
			entry = tile_entry_t'(16'($urandom));
			// Code 0 tiles on a checkerboard, their graphics all zero
			entry.code = (((i / 8) + i) % 2 == 0) ? 8'd0 : 8'(1 + $urandom % 255);
			fg_map[6'(i)] = entry;
		end
		for (i = 0; i < 16384; i++) begin
			bg_gfx[14'(i)] = 4'($urandom);
			fg_gfx[14'(i)] = (i < 64) ? 4'd0 : 4'($urandom);
		end
		for (i = 0; i < 256; i++) begin
			rg_prom[8'(i)] = 8'($urandom);
			b_prom[8'(i)] = 4'($urandom);
		end
	endtask

	// One layer's pixel at a raster position
	function automatic layer_pixel_t layer_lookup(input bit use_fg, input int h, input int v,
		input logic [5:0] scroll);
		int           x;
		logic [5:0]   map_idx;
		logic [13:0]  gfx_idx;
		tile_entry_t  entry;
		layer_pixel_t px;
		x = (h + int'(scroll)) % 64;
		// Eight tiles per map row
		map_idx = 6'((v / 8) * 8 + x / 8);
		entry = tile_entry_t'(use_fg ? fg_map[map_idx] : bg_map[map_idx]);
		// 64 nibbles per tile and 8 per tile row
		gfx_idx = 14'(int'(entry.code) * 64 + (v % 8) * 8 + x % 8);
		px.palette = entry.palette;
		px.index = use_fg ? fg_gfx[gfx_idx] : bg_gfx[gfx_idx];
		return px;
	endfunction

	task automatic check_output();
		video_sync_t  exp_sync;
		rgb_t         exp_rgb;
		layer_pixel_t bgp;
		layer_pixel_t fgp;
		layer_pixel_t win;
		bit           bg_vis;
		bit           fg_vis;
		logic [7:0]   pal_idx;
		exp_sync.hsync_n = !(ref_h >= `S86_H_SYNC_START &&
			ref_h < `S86_H_SYNC_START + `S86_H_SYNC_LEN);
		exp_sync.vsync_n = !(ref_v >= `S86_V_SYNC_START &&
			ref_v < `S86_V_SYNC_START + `S86_V_SYNC_LEN);
		exp_sync.hblank_n = (ref_h < `S86_H_ACTIVE);
		exp_sync.vblank_n = (ref_v < `S86_V_ACTIVE);
		bgp = layer_lookup(1'b0, ref_h, ref_v, bg_scroll_x);
		fgp = layer_lookup(1'b1, ref_h, ref_v, fg_scroll_x);
		bg_vis = layer_enable[0] && (bgp.index != 4'd0);
		fg_vis = layer_enable[1] && (fgp.index != 4'd0);
		// Higher priority wins when both layers show
		if (fg_vis && (!bg_vis || `S86_FG_PRIORITY > `S86_BG_PRIORITY))
			win = fgp;
		else if (bg_vis)
			win = bgp;
		else
			win = '0;
		pal_idx = 8'(win.palette * 16 + win.index);
		exp_rgb = '0;
		if (exp_sync.hblank_n && exp_sync.vblank_n) begin
			exp_rgb.red = rg_prom[pal_idx][3:0];
			exp_rgb.green = rg_prom[pal_idx][7:4];
			exp_rgb.blue = b_prom[pal_idx];
			if (layer_enable == 2'b11) begin
				if (fg_vis)
					cnt_fg_top++;
				else if (bg_vis)
					cnt_bg_show++;
				else
					cnt_backdrop++;
			end
		end
		assert (vid_sync == exp_sync) else begin
			$display("[ERROR] %s: sync at (%0d,%0d) expected %b actual %b",
				cur_test, ref_h, ref_v, exp_sync, vid_sync);
			mon_errs++;
		end
		assert (vid_rgb == exp_rgb) else begin
			$display("[ERROR] %s: rgb at (%0d,%0d) expected %h actual %h",
				cur_test, ref_h, ref_v, exp_rgb, vid_rgb);
			mon_errs++;
		end
	endtask

	////////////////////
	// Output monitor
	////////////////////

	// Outputs sampled on the falling edge
	always @(negedge clk) begin
		if (!arst_n) begin
			locked = 1'b0;
			prev_vsync_n = 1'b1;
		end else begin
			if (locked) begin
				ref_v = (ref_h < `S86_H_TOTAL - 1) ? ref_v :
					(ref_v == `S86_V_TOTAL - 1) ? 0 : ref_v + 1;
				ref_h = (ref_h + 1) % `S86_H_TOTAL;
			end
			// Frame sync falls at column 0 of the first sync line
			if (prev_vsync_n && !vid_sync.vsync_n) begin
				if (!locked) begin
					ref_h = 0;
					ref_v = `S86_V_SYNC_START;
					locked = 1'b1;
				end
				frame_count++;
			end
			prev_vsync_n = vid_sync.vsync_n;
			if (locked) check_output();
		end
	end

	task automatic start_test(input string name);
		cur_test = name;
		start_errs = main_errs + mon_errs;
	endtask

	task automatic end_test();
		tests_run++;
		if (main_errs + mon_errs == start_errs) begin
			$display("[PASS] %s", cur_test);
		end else begin
			$display("[FAIL] %s, %0d errors", cur_test, main_errs + mon_errs - start_errs);
			tests_failed++;
		end
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (arst_n !== 1'b1 && n < RESET_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (arst_n !== 1'b1) begin
			$display("Timeout in %s, reset never released", cur_test);
			timed_out = 1'b1;
		end
	endtask

	// Returns on the rising edge after the next frame sync
	task automatic wait_frame();
		int start;
		int n;
		start = frame_count;
		n = 0;
		while (frame_count == start && n < FRAME_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (frame_count == start) begin
			$display("Timeout in %s, no frame sync within %0d clocks", cur_test, n);
			timed_out = 1'b1;
		end
	endtask

	task automatic run_tests();
		int k;
		int fg_before;
		int bg_before;
		int bd_before;

		start_test("reset_state");
		wait_reset_release();
		if (timed_out)
			return;
		for (k = 0; k < `S86_PIPE_DEPTH; k++) begin
			if (k > 0) begin
				@(posedge clk);
				@(negedge clk);
			end
			assert (vid_sync == SYNC_IDLE && vid_rgb == '0) else begin
				$display("[ERROR] %s: clock %0d expected %b/%h actual %b/%h", cur_test, k,
					SYNC_IDLE, 12'h000, vid_sync, vid_rgb);
				main_errs++;
			end
		end
		end_test();

		// First sync locks the model and the second ends a checked frame
		start_test("sync_timing");
		wait_frame();
		if (timed_out)
			return;
		wait_frame();
		if (timed_out)
			return;
		end_test();

		start_test("bg_only");
		layer_enable <= 2'b01;
		wait_frame();
		if (timed_out)
			return;
		end_test();

		start_test("both_layers");
		fg_before = cnt_fg_top;
		bg_before = cnt_bg_show;
		bd_before = cnt_backdrop;
		layer_enable <= 2'b11;
		wait_frame();
		if (timed_out)
			return;
		assert (cnt_fg_top > fg_before && cnt_bg_show > bg_before && cnt_backdrop > bd_before)
		else begin
			$display("%s: not every overlap case appeared in the frame", cur_test);
			main_errs++;
		end
		end_test();

		start_test("layer_mask");
		layer_enable <= 2'b00;
		wait_frame();
		if (timed_out)
			return;
		layer_enable <= 2'b10;
		wait_frame();
		if (timed_out)
			return;
		end_test();

		// New scroll values only during vertical blank
		start_test("scroll");
		for (k = 0; k < 3; k++) begin
			bg_scroll_x <= 6'($urandom);
			fg_scroll_x <= 6'($urandom);
			layer_enable <= 2'b11;
			wait_frame();
			if (timed_out)
				return;
		end
		end_test();
	endtask

	initial begin
		bg_scroll_x = '0;
		fg_scroll_x = '0;
		layer_enable = 2'b01;
		main_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		fill_memories();
		run_tests();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed,
			main_errs + mon_errs);
		if (!timed_out && tests_failed == 0 && main_errs + mon_errs == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== s86_tb_clk.sv ====
`default_nettype none

module s86_tb_clk (
	output logic clk,
	output logic arst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Reset held for three clocks, released on a rising edge
	initial begin
		arst_n = 1'b0;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== s86_tile_layer.sv ====
`default_nettype none

module s86_tile_layer (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire s86_pkg::raster_pos_t pos,
	input  wire [5:0]             scroll_x,
	output logic [5:0]            map_addr,
	input  wire [15:0]            map_data,
	output logic [13:0]           gfx_addr,
	input  wire [3:0]             gfx_data,
	output s86_pkg::layer_pixel_t pixel
);

	import s86_pkg::*;

	// Scrolled column, wraps on the 64 pixel map
	logic [5:0] col_x;
	// Row straight from the line counter
	logic [5:0] row_y;

	// Stage 1 registers
	tile_entry_t entry_q;
	logic [2:0]  fine_x_q;
	logic [2:0]  fine_y_q;

	////////////////////
	// Map fetch
	////////////////////

	// Only low six bits of hcount matter, line is 64 clocks
	assign col_x = pos.hcount[5:0] + scroll_x;
	assign row_y = pos.vcount;

	// 8x8 tiles, map is 8 rows of 8 tiles
	// Row select in upper bits, column in lower bits
	assign map_addr = {row_y[5:3], col_x[5:3]};

	// Map word comes back in the same clock
	// Fine offsets ride along for the graphics fetch
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			entry_q <= '0;
			fine_x_q <= '0;
			fine_y_q <= '0;
		end else begin
			entry_q <= tile_entry_t'(map_data);
			fine_x_q <= col_x[2:0];
			fine_y_q <= row_y[2:0];
		end
	end

	////////////////////
	// Graphics fetch
	////////////////////

	// One nibble per pixel, 64 pixels per tile code
	// Code picks the tile, then row in tile, then pixel in row
	assign gfx_addr = {entry_q.code, fine_y_q, fine_x_q};

	// Pixel index joins the palette of its own tile
	// Index 0 passes through untouched, mixer treats it as see-through
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pixel <= '0;
		end else begin
			pixel.palette <= entry_q.palette;
			pixel.index <= gfx_data;
		end
	end

	// Two positions in flight here, map stage and graphics stage

endmodule

`default_nettype wire

// ==== s86_video.sv ====
`default_nettype none

`include "s86_cfg.svh"

module s86_video (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire [5:0]             bg_scroll_x,
	input  wire [5:0]             fg_scroll_x,
	input  wire [1:0]             layer_enable,
	output logic [5:0]            bg_map_addr,
	input  wire [15:0]            bg_map_data,
	output logic [13:0]           bg_gfx_addr,
	input  wire [3:0]             bg_gfx_data,
	output logic [5:0]            fg_map_addr,
	input  wire [15:0]            fg_map_data,
	output logic [13:0]           fg_gfx_addr,
	input  wire [3:0]             fg_gfx_data,
	output logic [7:0]            rg_addr,
	input  wire [2*`S86_COMPONENT_DEPTH-1:0] rg_data,
	output logic [7:0]            b_addr,
	input  wire [`S86_COMPONENT_DEPTH-1:0]   b_data,
	output s86_pkg::video_sync_t  vid_sync,
	output s86_pkg::rgb_t         vid_rgb
);

	import s86_pkg::*;

	raster_pos_t  pos;
	video_sync_t  sync;
	layer_pixel_t bg_pixel;
	layer_pixel_t fg_pixel;
	layer_pixel_t mix_pixel;
	logic         pal_blank_n;

	// Sync delay line, one stage per pipeline clock
	video_sync_t sync_dly [`S86_PIPE_DEPTH];

	s86_video_timing timing_i (
		.clk(clk), .arst_n(arst_n), .pos(pos), .sync(sync)
	);

	s86_tile_layer bg_layer_i (
		.clk(clk), .arst_n(arst_n), .pos(pos), .scroll_x(bg_scroll_x),
		.map_addr(bg_map_addr), .map_data(bg_map_data),
		.gfx_addr(bg_gfx_addr), .gfx_data(bg_gfx_data), .pixel(bg_pixel)
	);

	s86_tile_layer fg_layer_i (
		.clk(clk), .arst_n(arst_n), .pos(pos), .scroll_x(fg_scroll_x),
		.map_addr(fg_map_addr), .map_data(fg_map_data),
		.gfx_addr(fg_gfx_addr), .gfx_data(fg_gfx_data), .pixel(fg_pixel)
	);

	s86_layer_mixer mixer_i (
		.clk(clk), .arst_n(arst_n), .bg(bg_pixel), .fg(fg_pixel),
		.layer_enable(layer_enable), .pixel(mix_pixel)
	);

	// Blank taken one stage before the end, lines up with mixer output
	assign pal_blank_n = sync_dly[`S86_PIPE_DEPTH-2].hblank_n &
		sync_dly[`S86_PIPE_DEPTH-2].vblank_n;

	s86_palette palette_i (
		.clk(clk), .arst_n(arst_n), .pixel(mix_pixel), .blank_n(pal_blank_n),
		.rg_addr(rg_addr), .rg_data(rg_data), .b_addr(b_addr), .b_data(b_data),
		.rgb(vid_rgb)
	);

	////////////////////
	// Sync delay
	////////////////////

	// Reset state is syncs idle and blanked
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `S86_PIPE_DEPTH; i++) begin
				sync_dly[i] <= '{hsync_n: 1'b1, vsync_n: 1'b1, hblank_n: 1'b0, vblank_n: 1'b0};
			end
		end else begin
			sync_dly[0] <= sync;
			for (int i = 1; i < `S86_PIPE_DEPTH; i++) begin
				sync_dly[i] <= sync_dly[i-1];
			end
		end
	end

	assign vid_sync = sync_dly[`S86_PIPE_DEPTH-1];

endmodule

`default_nettype wire

// ==== s86_video_timing.sv ====
`default_nettype none

`include "s86_cfg.svh"

module s86_video_timing (
	input  wire                  clk,
	input  wire                  arst_n,
	output s86_pkg::raster_pos_t pos,
	output s86_pkg::video_sync_t sync
);

	import s86_pkg::*;

	logic        h_last;
	logic        v_last;
	raster_pos_t pos_next;
	video_sync_t sync_next;

	////////////////////
	// Counters
	////////////////////

	// End of line and end of frame
	assign h_last = (pos.hcount == 7'(`S86_H_TOTAL - 1));
	assign v_last = (pos.vcount == 6'(`S86_V_TOTAL - 1));

	always_comb begin
		pos_next = pos;
		if (h_last) begin
			pos_next.hcount = '0;
			// Line advances on horizontal wrap
			pos_next.vcount = v_last ? '0 : pos.vcount + 6'd1;
		end else begin
			pos_next.hcount = pos.hcount + 7'd1;
		end
	end

	////////////////////
	// Sync and blank
	////////////////////

	// Decoded from next position so registered strobes match registered counters
	always_comb begin
		sync_next.hblank_n = (pos_next.hcount < 7'(`S86_H_ACTIVE));
		sync_next.vblank_n = (pos_next.vcount < 6'(`S86_V_ACTIVE));
		// Low inside line sync window
		sync_next.hsync_n = !((pos_next.hcount >= 7'(`S86_H_SYNC_START)) &&
			(pos_next.hcount < 7'(`S86_H_SYNC_START + `S86_H_SYNC_LEN)));
		// Low inside frame sync window, whole lines
		sync_next.vsync_n = !((pos_next.vcount >= 6'(`S86_V_SYNC_START)) &&
			(pos_next.vcount < 6'(`S86_V_SYNC_START + `S86_V_SYNC_LEN)));
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pos <= '0;
			// Position 0 is visible and outside both sync windows
			sync.hsync_n <= 1'b1;
			sync.vsync_n <= 1'b1;
			sync.hblank_n <= 1'b1;
			sync.vblank_n <= 1'b1;
		end else begin
			pos <= pos_next;
			sync <= sync_next;
		end
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
s86_pkg.sv
s86_video_timing.sv
s86_tile_layer.sv
s86_layer_mixer.sv
s86_palette.sv
s86_video.sv
s86_tb_clk.sv
s86_tb.sv
